/* cart_pkg.sv */
// **********************************************************************
// Cartridge mapper package
// Bus types, mapper kind codes, hotspot addresses and Superchip RAM
// decode constants shared by the bank-switching stages
// **********************************************************************

package cart_pkg;

	typedef logic [12:0] cart_addr_t;
	typedef logic [7:0]  cart_data_t;
	typedef logic [10:0] ram_addr_t;
	typedef logic [7:0]  bank_t;
	typedef logic [1:0]  seg_sel_t;
	typedef logic [2:0]  mapper_t;

	// Mapper kinds
	localparam mapper_t MAPPER_4K = 3'd0;
	localparam mapper_t MAPPER_F8 = 3'd1;
	localparam mapper_t MAPPER_F6 = 3'd2;
	localparam mapper_t MAPPER_F4 = 3'd3;
	localparam mapper_t MAPPER_E0 = 3'd4;
	localparam mapper_t MAPPER_3F = 3'd5;

	// First hotspot of each window, bank n sits at base + n
	localparam cart_addr_t HOT_F8_BASE = 13'h1FF8;
	localparam cart_addr_t HOT_F6_BASE = 13'h1FF6;
	localparam cart_addr_t HOT_F4_BASE = 13'h1FF4;
	localparam cart_addr_t HOT_E0_BASE = 13'h1FE0;
	localparam cart_addr_t HOT_3F_ADDR = 13'h003F;

	// Number of hotspots in each window
	localparam cart_addr_t HOT_F8_COUNT = 13'd2;
	localparam cart_addr_t HOT_F6_COUNT = 13'd4;
	localparam cart_addr_t HOT_F4_COUNT = 13'd8;

	// E0 has three switchable 1K slots, the top one is fixed
	localparam int    E0_SLOTS    = 3;
	localparam bank_t E0_TOP_BANK = 8'd7;

	// 3F upper 2K always maps to the last bank
	localparam bank_t FIXED_3F_BANK = 8'hFF;

	// F8 comes out of reset in its upper bank
	localparam bank_t START_BANK_F8 = 8'd1;

	// Superchip RAM page in a_in[12:8] and number of offset bits
	localparam logic [4:0] SC_PAGE     = 5'b10000;
	localparam int         SC_RAM_BITS = 7;

endpackage

/* hotspot_decode.sv */
// **********************************************************************
// Hotspot decode
// Watches the cartridge address and data bus and turns hotspot
// accesses of the selected mapper into bank-write commands
// **********************************************************************

module hotspot_decode import cart_pkg::*; (
	input  mapper_t    mapper,
	input  logic       a_change,
	input  cart_addr_t a_in,
	input  cart_data_t d_in,
	output logic       bank_wr,
	output seg_sel_t   bank_seg,
	output bank_t      bank_val
);

	// Window of the F8/F6/F4 family
	cart_addr_t hot_base;
	cart_addr_t hot_count;
	logic       hot_window;
	cart_addr_t hot_offset;
	logic       window_hit;

	// E0 slot decode on bits 12:3
	logic [9:0] e0_line;
	logic [9:0] e0_slot;
	logic       e0_hit;

	logic       f3_hit;

	always_comb begin
		hot_base   = HOT_F8_BASE;
		hot_count  = HOT_F8_COUNT;
		hot_window = 1'b0;
		case (mapper)
			MAPPER_F8: begin
				hot_base   = HOT_F8_BASE;
				hot_count  = HOT_F8_COUNT;
				hot_window = 1'b1;
			end
			MAPPER_F6: begin
				hot_base   = HOT_F6_BASE;
				hot_count  = HOT_F6_COUNT;
				hot_window = 1'b1;
			end
			MAPPER_F4: begin
				hot_base   = HOT_F4_BASE;
				hot_count  = HOT_F4_COUNT;
				hot_window = 1'b1;
			end
			default: ;
		endcase
	end

	// Offset wraps below the base, so the lower bound is checked as well
	assign hot_offset = a_in - hot_base;
	assign window_hit = hot_window && (a_in >= hot_base) && (hot_offset < hot_count);

	assign e0_line = a_in[12:3];
	assign e0_slot = e0_line - HOT_E0_BASE[12:3];
	assign e0_hit  = (mapper == MAPPER_E0) && (e0_line >= HOT_E0_BASE[12:3]) &&
		(e0_slot < 10'(E0_SLOTS));

	// 3F latches the data bus on any access, strobe or not
	assign f3_hit = (mapper == MAPPER_3F) && (a_in == HOT_3F_ADDR);

	always_comb begin
		bank_wr  = 1'b0;
		bank_seg = '0;
		bank_val = '0;
		if (a_change && window_hit) begin
			bank_wr  = 1'b1;
			bank_val = bank_t'(hot_offset);
		end else if (a_change && e0_hit) begin
			bank_wr  = 1'b1;
			bank_seg = seg_sel_t'(e0_slot);
			bank_val = bank_t'(a_in[2:0]);
		end else if (f3_hit) begin
			bank_wr  = 1'b1;
			bank_val = d_in;
		end
	end

endmodule

/* bank_registers.sv */
// **********************************************************************
// Bank registers
// Holds the three segment bank registers, loads the selected one on a
// bank write and applies the start bank of the mapper on reset
// **********************************************************************

module bank_registers import cart_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  mapper_t  mapper,
	input  logic     bank_wr,
	input  seg_sel_t bank_seg,
	input  bank_t    bank_val,
	output bank_t    seg0,
	output bank_t    seg1,
	output bank_t    seg2
);

	bank_t start_bank;

	// Only F8 boots from a bank other than zero
	assign start_bank = (mapper == MAPPER_F8) ? START_BANK_F8 : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			seg0 <= start_bank;
			seg1 <= '0;
			seg2 <= '0;
		end else if (bank_wr) begin
			case (bank_seg)
				2'd0: seg0 <= bank_val;
				2'd1: seg1 <= bank_val;
				2'd2: seg2 <= bank_val;
				default: ;
			endcase
		end
	end

endmodule

/* cart_bus_map.sv */
// **********************************************************************
// Cartridge bus map
// Forms the physical ROM address from the bank registers, and decodes
// the Superchip RAM ports and the cartridge output enable
// **********************************************************************

module cart_bus_map import cart_pkg::*; #(
	parameter int ROM_ADDR_W = 19
) (
	input  mapper_t                 mapper,
	input  logic                    sc,
	input  cart_addr_t              a_in,
	input  bank_t                   seg0,
	input  bank_t                   seg1,
	input  bank_t                   seg2,
	output logic [ROM_ADDR_W-1:0]   rom_a,
	output logic                    ram_sel,
	output logic                    ram_rw,
	output ram_addr_t               ram_a,
	output logic                    cart_oe
);

	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

	bank_t e0_bank;
	bank_t f3_bank;

	// E0 picks one of four 1K slots, the last one is fixed
	always_comb begin
		case (a_in[11:10])
			2'd0:    e0_bank = seg0;
			2'd1:    e0_bank = seg1;
			2'd2:    e0_bank = seg2;
			default: e0_bank = E0_TOP_BANK;
		endcase
	end

	assign f3_bank = a_in[11] ? FIXED_3F_BANK : seg0;

	always_comb begin
		case (mapper)
			MAPPER_F8, MAPPER_F6, MAPPER_F4:
				rom_a = (rom_addr_t'(seg0) << 12) | rom_addr_t'(a_in[11:0]);
			MAPPER_E0:
				rom_a = (rom_addr_t'(e0_bank) << 10) | rom_addr_t'(a_in[9:0]);
			MAPPER_3F:
				rom_a = (rom_addr_t'(f3_bank) << 11) | rom_addr_t'(a_in[10:0]);
			default:
				rom_a = rom_addr_t'(a_in[11:0]);
		endcase
	end

	// Superchip RAM, write port below read port within one page
	assign ram_sel = sc && (a_in[12:8] == SC_PAGE);
	assign ram_rw  = sc ? a_in[SC_RAM_BITS] : 1'b1;
	assign ram_a   = ram_addr_t'(a_in[SC_RAM_BITS-1:0]);

	// Cartridge drives the bus in its own half unless RAM is being written
	assign cart_oe = a_in[12] && !(ram_sel && !ram_rw);

endmodule

/* cart_mapper_top.sv */
// **********************************************************************
// Cartridge mapper top level
// Hotspot decode, bank registers and bus map of an Atari 2600
// bank-switching cartridge
// **********************************************************************

module cart_mapper_top import cart_pkg::*; #(
	parameter int ROM_ADDR_W = 19
) (
	input  logic                  clk,
	input  logic                  reset,
	input  mapper_t               mapper,
	input  logic                  sc,
	input  logic                  a_change,
	input  cart_addr_t            a_in,
	input  cart_data_t            d_in,
	output logic [ROM_ADDR_W-1:0] rom_a,
	output logic                  ram_sel,
	output logic                  ram_rw,
	output ram_addr_t             ram_a,
	output logic                  cart_oe
);

	logic     bank_wr;
	seg_sel_t bank_seg;
	bank_t    bank_val;
	bank_t    seg0;
	bank_t    seg1;
	bank_t    seg2;

	hotspot_decode u_decode (
		.mapper   (mapper),
		.a_change (a_change),
		.a_in     (a_in),
		.d_in     (d_in),
		.bank_wr  (bank_wr),
		.bank_seg (bank_seg),
		.bank_val (bank_val)
	);

	bank_registers u_banks (
		.clk      (clk),
		.reset    (reset),
		.mapper   (mapper),
		.bank_wr  (bank_wr),
		.bank_seg (bank_seg),
		.bank_val (bank_val),
		.seg0     (seg0),
		.seg1     (seg1),
		.seg2     (seg2)
	);

	cart_bus_map #(
		.ROM_ADDR_W (ROM_ADDR_W)
	) u_bus_map (
		.mapper  (mapper),
		.sc      (sc),
		.a_in    (a_in),
		.seg0    (seg0),
		.seg1    (seg1),
		.seg2    (seg2),
		.rom_a   (rom_a),
		.ram_sel (ram_sel),
		.ram_rw  (ram_rw),
		.ram_a   (ram_a),
		.cart_oe (cart_oe)
	);

endmodule

/* cart_mapper_properties.sv */
// **********************************************************************
// Cartridge mapper bus properties
// Concurrent checks on the Superchip RAM controls and output enable
// **********************************************************************

module cart_mapper_properties import cart_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       sc,
	input cart_addr_t a_in,
	input logic       ram_sel,
	input logic       ram_rw,
	input logic       cart_oe
);

	// Superchip RAM only exists on sc cartridges
	sel_needs_sc: assert property (@(posedge clk) disable iff (reset) ram_sel |-> sc)
		else $error("ram_sel is high while sc is low");

	no_write_without_sc: assert property (@(posedge clk) disable iff (reset) !sc |-> ram_rw)
		else $error("ram_rw went low while sc is low");

	// Cartridge never drives the bus in the lower 4K
	oe_only_upper_half: assert property (@(posedge clk) disable iff (reset)
		!a_in[12] |-> !cart_oe)
		else $error("cart_oe is high with a_in bit 12 low");

endmodule

bind cart_mapper_top cart_mapper_properties u_props (
	.clk     (clk),
	.reset   (reset),
	.sc      (sc),
	.a_in    (a_in),
	.ram_sel (ram_sel),
	.ram_rw  (ram_rw),
	.cart_oe (cart_oe)
);

/* cart_model.svh */
// **********************************************************************
// Cartridge mapper reference model
// Tracks the segment banks from bus traffic and predicts the ROM
// address, the Superchip RAM controls and the output enable
// **********************************************************************

`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

bank_t model_banks [0:2];

// F8 starts in its upper bank, everything else in bank 0
function automatic void model_reset(input mapper_t kind);
	model_banks[0] = (kind == MAPPER_F8) ? 8'd1 : 8'd0;
	model_banks[1] = 8'd0;
	model_banks[2] = 8'd0;
endfunction

function automatic void model_update(input mapper_t kind, input logic strobe,
	input cart_addr_t addr, input cart_data_t data);
	int slot;
	case (kind)
		MAPPER_F8:
			if (strobe && (addr inside {[13'h1FF8:13'h1FF9]}))
				model_banks[0] = bank_t'(addr - 13'h1FF8);
		MAPPER_F6:
			if (strobe && (addr inside {[13'h1FF6:13'h1FF9]}))
				model_banks[0] = bank_t'(addr - 13'h1FF6);
		MAPPER_F4:
			if (strobe && (addr inside {[13'h1FF4:13'h1FFB]}))
				model_banks[0] = bank_t'(addr - 13'h1FF4);
		MAPPER_E0:
			if (strobe && (addr inside {[13'h1FE0:13'h1FF7]})) begin
				slot = (addr - 13'h1FE0) / 8;
				model_banks[slot] = bank_t'(addr[2:0]);
			end
		// No strobe needed here
		MAPPER_3F:
			if (addr == 13'h003F)
				model_banks[0] = data;
		default: ;
	endcase
endfunction

function automatic rom_addr_t model_rom(input mapper_t kind, input cart_addr_t addr);
	bank_t bank;
	case (kind)
		MAPPER_F8, MAPPER_F6, MAPPER_F4:
			return rom_addr_t'(model_banks[0]) * 4096 + rom_addr_t'(addr[11:0]);
		MAPPER_E0: begin
			bank = (addr[11:10] == 2'd3) ? 8'd7 : model_banks[addr[11:10]];
			return rom_addr_t'(bank) * 1024 + rom_addr_t'(addr[9:0]);
		end
		MAPPER_3F: begin
			bank = addr[11] ? 8'hFF : model_banks[0];
			return rom_addr_t'(bank) * 2048 + rom_addr_t'(addr[10:0]);
		end
		default:
			return rom_addr_t'(addr[11:0]);
	endcase
endfunction

function automatic logic model_ram_sel(input logic sc_bit, input cart_addr_t addr);
	return sc_bit && (addr inside {[13'h1000:13'h10FF]});
endfunction

function automatic logic model_ram_rw(input logic sc_bit, input cart_addr_t addr);
	return sc_bit ? addr[7] : 1'b1;
endfunction

function automatic ram_addr_t model_ram_a(input cart_addr_t addr);
	return ram_addr_t'(addr[6:0]);
endfunction

function automatic logic model_cart_oe(input logic sc_bit, input cart_addr_t addr);
	logic ram_write;
	ram_write = model_ram_sel(sc_bit, addr) && !model_ram_rw(sc_bit, addr);
	return addr[12] && !ram_write;
endfunction

`endif

/* tb_cart_mapper.sv */
// **********************************************************************
// Cartridge mapper testbench
// Runs every mapper kind from reset under random bus traffic and
// compares the DUT outputs with a reference model
// **********************************************************************

module tb_cart_mapper import cart_pkg::*; ();

	localparam int ROM_ADDR_W     = 19;
	localparam int RESET_CYCLES   = 8;
	localparam int RUN_CYCLES     = 400;
	localparam int NUM_KINDS      = 6;
	localparam int TIMEOUT_CYCLES = NUM_KINDS * RUN_CYCLES + 600;
	localparam int RAND_SEED      = 47;

	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

	`include "cart_model.svh"

	logic       clk;
	logic       reset;
	mapper_t    mapper;
	logic       sc;
	logic       a_change;
	cart_addr_t a_in;
	cart_data_t d_in;
	rom_addr_t  rom_a;
	logic       ram_sel;
	logic       ram_rw;
	ram_addr_t  ram_a;
	logic       cart_oe;

	mapper_t run_kinds [0:5] = '{MAPPER_4K, MAPPER_F8, MAPPER_F6, MAPPER_F4,
		MAPPER_E0, MAPPER_3F};

	int unsigned seed_val;
	int          cycle_count = 0;
	int          check_count = 0;
	int          rom_errors  = 0;
	int          ram_errors  = 0;
	int          bit_errors  = 0;
	int          total_errors;

	cart_mapper_top #(
		.ROM_ADDR_W (ROM_ADDR_W)
	) dut (
		.clk      (clk),
		.reset    (reset),
		.mapper   (mapper),
		.sc       (sc),
		.a_change (a_change),
		.a_in     (a_in),
		.d_in     (d_in),
		.rom_a    (rom_a),
		.ram_sel  (ram_sel),
		.ram_rw   (ram_rw),
		.ram_a    (ram_a),
		.cart_oe  (cart_oe)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles",
				TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check_rom(input string name, input rom_addr_t actual,
		input rom_addr_t expected);
		if (actual !== expected) begin
			rom_errors++;
			$display("Error: %s = 0x%0h, expected 0x%0h (mapper 0x%0h, a_in 0x%0h)",
				name, actual, expected, mapper, a_in);
		end
	endtask

	task automatic check_ram(input string name, input ram_addr_t actual,
		input ram_addr_t expected);
		if (actual !== expected) begin
			ram_errors++;
			$display("Error: %s = 0x%0h, expected 0x%0h (a_in 0x%0h)",
				name, actual, expected, a_in);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			bit_errors++;
			$display("Error: %s = 0x%0h, expected 0x%0h (sc 0x%0h, a_in 0x%0h)",
				name, actual, expected, sc, a_in);
		end
	endtask

	task automatic check_outputs();
		check_count++;
		check_rom("rom_a", rom_a, model_rom(mapper, a_in));
		check_ram("ram_a", ram_a, model_ram_a(a_in));
		check_bit("ram_sel", ram_sel, model_ram_sel(sc, a_in));
		check_bit("ram_rw", ram_rw, model_ram_rw(sc, a_in));
		check_bit("cart_oe", cart_oe, model_cart_oe(sc, a_in));
	endtask

	// A third hotspots, a third Superchip page, a third anywhere
	function automatic cart_addr_t pick_address(input mapper_t kind);
		int unsigned choice;
		cart_addr_t  addr;
		choice = $urandom_range(0, 2);
		if (choice == 0) begin
			case (kind)
				MAPPER_F8: addr = 13'h1FF8 + cart_addr_t'($urandom_range(0, 1));
				MAPPER_F6: addr = 13'h1FF6 + cart_addr_t'($urandom_range(0, 3));
				MAPPER_F4: addr = 13'h1FF4 + cart_addr_t'($urandom_range(0, 7));
				MAPPER_E0: addr = 13'h1FE0 + cart_addr_t'($urandom_range(0, 23));
				MAPPER_3F: addr = 13'h003F;
				default:   addr = 13'h1FE0 + cart_addr_t'($urandom_range(0, 31));
			endcase
		end else if (choice == 1) begin
			addr = 13'h1000 + cart_addr_t'($urandom_range(0, 255));
		end else begin
			addr = cart_addr_t'($urandom);
		end
		return addr;
	endfunction

	task automatic apply_reset(input mapper_t kind);
		@(posedge clk);
		reset    <= 1'b1;
		mapper   <= kind;
		sc       <= 1'b0;
		a_change <= 1'b0;
		a_in     <= '0;
		d_in     <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		a_in  <= 13'h1000;
		model_reset(kind);
		// Start bank seen through slot 0, RAM page addressed with sc low
		@(negedge clk);
		check_outputs();
		model_update(kind, a_change, a_in, d_in);
	endtask

	task automatic run_random(input mapper_t kind);
		for (int i = 0; i < RUN_CYCLES; i++) begin
			@(posedge clk);
			sc       <= 1'($urandom_range(0, 1));
			a_change <= 1'($urandom_range(0, 1));
			a_in     <= pick_address(kind);
			d_in     <= cart_data_t'($urandom);
			@(negedge clk);
			check_outputs();
			model_update(kind, a_change, a_in, d_in);
		end
	endtask

	initial begin
		seed_val = $urandom(RAND_SEED);
		reset    <= 1'b1;
		mapper   <= MAPPER_4K;
		sc       <= 1'b0;
		a_change <= 1'b0;
		a_in     <= '0;
		d_in     <= '0;
		for (int k = 0; k < NUM_KINDS; k++) begin
			apply_reset(run_kinds[k]);
			run_random(run_kinds[k]);
		end
		total_errors = rom_errors + ram_errors + bit_errors;
		$display("Checks %0d, rom_a errors %0d, ram_a errors %0d, control bit errors %0d",
			check_count, rom_errors, ram_errors, bit_errors);
		if (total_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
cart_pkg.sv
hotspot_decode.sv
bank_registers.sv
cart_bus_map.sv
cart_mapper_top.sv
cart_mapper_properties.sv
tb_cart_mapper.sv
